//--- src.f
vec_pkg.sv
vec_issue_if.sv
vec_dispatcher.sv
vec_lane.sv
vec_result_collector.sv
vec_unit.sv
tb_vec_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the vec_unit testbench with Verilator, then judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_vec_unit -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

//--- tb_vec_unit.sv
// Self-checking testbench for vec_unit; drives core requests and checks every response sum

`default_nettype none

module tb_vec_unit;

  localparam int NrLanes    = 4;
  localparam int DriveDelay = 1;
  // 79 instructions at no more than NrLanes+4 cycles each, plus reset, with wide margin
  localparam int MaxCycles  = 2000;

  logic                         clk_i;
  logic                         rst_n_i;
  logic                         req_valid_i;
  logic                         req_ready_o;
  vec_pkg::vec_op_e             req_op_i;
  vec_pkg::vreg_idx_t           req_vd_i;
  vec_pkg::vreg_idx_t           req_vs1_i;
  vec_pkg::vreg_idx_t           req_vs2_i;
  vec_pkg::elem_t               req_scalar_i;
  vec_pkg::elem_t [NrLanes-1:0] req_vec_i;
  logic                         resp_valid_o;
  vec_pkg::elem_t               resp_data_o;

  vec_unit #(
    .NrLanes(NrLanes)
  ) uut (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .req_op_i    (req_op_i    ),
    .req_vd_i    (req_vd_i    ),
    .req_vs1_i   (req_vs1_i   ),
    .req_vs2_i   (req_vs2_i   ),
    .req_scalar_i(req_scalar_i),
    .req_vec_i   (req_vec_i   ),
    .resp_valid_o(resp_valid_o),
    .resp_data_o (resp_data_o )
  );

  // Shadow register file, one element per lane and register
  vec_pkg::elem_t model_vrf [vec_pkg::NrVRegs][NrLanes];
  vec_pkg::elem_t exp_q [$];
  logic [31:0]    rand_state = 32'h86daae4a;
  int             accept_count, resp_count, cycle_count;
  int             check_count, error_count, test_count;
  int             test_checks, test_errors;

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_count++;

  ////////////////////////////////////////////////////////////////////////////
  // Random data and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  function automatic vec_pkg::vreg_idx_t rand_reg();
    return vec_pkg::vreg_idx_t'(next_rand() >> 29);
  endfunction

  function automatic vec_pkg::elem_t [NrLanes-1:0] rand_vec();
    vec_pkg::elem_t [NrLanes-1:0] v;
    for (int i = 0; i < NrLanes; i++) v[i] = next_rand();
    return v;
  endfunction

  // Element that one lane writes or reports
  function automatic vec_pkg::elem_t lane_result(input vec_pkg::vec_op_e op, input int lane,
      input vec_pkg::vreg_idx_t vs1, input vec_pkg::vreg_idx_t vs2,
      input vec_pkg::elem_t scalar, input vec_pkg::elem_t [NrLanes-1:0] vec);
    vec_pkg::elem_t a;
    vec_pkg::elem_t b;
    a = model_vrf[vs1][lane];
    b = model_vrf[vs2][lane];
    case (op)
      vec_pkg::VOP_LOAD:  return vec[lane];
      vec_pkg::VOP_ADD:   return a + b;
      vec_pkg::VOP_SUB:   return a - b;
      vec_pkg::VOP_AND:   return a & b;
      vec_pkg::VOP_XOR:   return a ^ b;
      vec_pkg::VOP_BCAST: return scalar;
      default:            return a;
    endcase
  endfunction

  // Wrapping sum over all lanes, taken before the register write
  function automatic vec_pkg::elem_t expected_sum(input vec_pkg::vec_op_e op,
      input vec_pkg::vreg_idx_t vs1, input vec_pkg::vreg_idx_t vs2,
      input vec_pkg::elem_t scalar, input vec_pkg::elem_t [NrLanes-1:0] vec);
    vec_pkg::elem_t sum;
    sum = '0;
    for (int i = 0; i < NrLanes; i++) sum = sum + lane_result(op, i, vs1, vs2, scalar, vec);
    return sum;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checking and reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input vec_pkg::elem_t got, input vec_pkg::elem_t exp,
      input string msg);
    check_count++;
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %h, expected %h", $time, msg, got, exp);
      error_count++;
    end
  endtask

  task automatic begin_test();
    test_checks = check_count;
    test_errors = error_count;
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("Test %s finished: %0d checks, %0d errors", name,
             check_count - test_checks, error_count - test_errors);
  endtask

  task automatic finish_run();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  // Compare process samples outputs at the falling edge
  always @(negedge clk_i) begin
    if (rst_n_i && accept_count != resp_count && req_ready_o) begin
      $display("Error at time %0t: ready is high while an instruction is in flight", $time);
      error_count++;
    end
    if (rst_n_i && resp_valid_o) begin
      // Every pulse counts, stray ones included
      resp_count++;
      if (exp_q.size() == 0) begin
        $display("Error at time %0t: response arrived with no instruction outstanding", $time);
        error_count++;
      end else begin
        check_value(resp_data_o, exp_q.pop_front(), "response sum");
      end
    end
  end

  initial begin
    wait (cycle_count >= MaxCycles);
    $display("Error: the run did not finish within %0d cycles", MaxCycles);
    error_count++;
    finish_run();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Called just after a rising edge, returns just after the acceptance edge
  task automatic send(input vec_pkg::vec_op_e op, input vec_pkg::vreg_idx_t vd,
      input vec_pkg::vreg_idx_t vs1, input vec_pkg::vreg_idx_t vs2,
      input vec_pkg::elem_t scalar, input vec_pkg::elem_t [NrLanes-1:0] vec);
    req_valid_i  = 1'b1;
    req_op_i     = op;
    req_vd_i     = vd;
    req_vs1_i    = vs1;
    req_vs2_i    = vs2;
    req_scalar_i = scalar;
    req_vec_i    = vec;
    while (!req_ready_o) begin
      @(posedge clk_i);
      #DriveDelay;
    end
    exp_q.push_back(expected_sum(op, vs1, vs2, scalar, vec));
    if (op != vec_pkg::VOP_REDSUM) begin
      for (int i = 0; i < NrLanes; i++) begin
        model_vrf[vd][i] = lane_result(op, i, vs1, vs2, scalar, vec);
      end
    end
    @(posedge clk_i);
    #DriveDelay;
    accept_count++;
  endtask

  // Drop valid and wait for every outstanding response
  task automatic drain();
    req_valid_i = 1'b0;
    while (exp_q.size() != 0) @(posedge clk_i);
    #DriveDelay;
  endtask

  initial begin
    int         base;
    logic [2:0] op_bits;
    vec_pkg::vreg_idx_t vd, vs1;
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = vec_pkg::VOP_LOAD;
    req_vd_i     = '0;
    req_vs1_i    = '0;
    req_vs2_i    = '0;
    req_scalar_i = '0;
    req_vec_i    = '0;
    for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
      for (int i = 0; i < NrLanes; i++) model_vrf[r][i] = '0;
    end
    repeat (8) @(posedge clk_i);
    #DriveDelay;
    rst_n_i = 1'b1;

    begin_test();
    check_value(vec_pkg::elem_t'(req_ready_o), 32'd1, "ready after reset");
    check_value(vec_pkg::elem_t'(resp_valid_o), 32'd0, "response valid after reset");
    for (int r = 0; r < vec_pkg::NrVRegs; r++) send(vec_pkg::VOP_REDSUM, '0, 3'(r), '0, '0, '0);
    drain();
    end_test("reset");

    begin_test();
    for (int r = 0; r < vec_pkg::NrVRegs; r++) send(vec_pkg::VOP_LOAD, 3'(r), '0, '0, '0, rand_vec());
    for (int r = 0; r < vec_pkg::NrVRegs; r++) send(vec_pkg::VOP_REDSUM, '0, 3'(r), '0, '0, '0);
    drain();
    end_test("load");

    begin_test();
    for (int n = 0; n < 16; n++) begin
      op_bits = 3'(32'd1 + (next_rand() % 32'd4));
      vs1     = rand_reg();
      // Every fourth instruction overwrites its first source
      vd      = (n % 4 == 0) ? vs1 : rand_reg();
      send(vec_pkg::vec_op_e'(op_bits), vd, vs1, rand_reg(), '0, '0);
    end
    drain();
    end_test("alu");

    begin_test();
    for (int n = 0; n < 3; n++) begin
      vd = rand_reg();
      send(vec_pkg::VOP_BCAST, vd, '0, '0, next_rand(), '0);
      send(vec_pkg::VOP_REDSUM, '0, vd, '0, '0, '0);
      send(vec_pkg::VOP_ADD, rand_reg(), vd, rand_reg(), '0, '0);
    end
    drain();
    end_test("broadcast");

    begin_test();
    base = resp_count;
    for (int n = 0; n < 30; n++) begin
      op_bits = 3'(next_rand() % 32'd7);
      send(vec_pkg::vec_op_e'(op_bits), rand_reg(), rand_reg(), rand_reg(), next_rand(),
           rand_vec());
    end
    drain();
    // Quiet window longer than the slowest response latency
    repeat (NrLanes + 2) @(posedge clk_i);
    #DriveDelay;
    check_value(vec_pkg::elem_t'(resp_count - base), 32'd30, "responses under back-pressure");
    end_test("back-pressure");

    finish_run();
  end

endmodule : tb_vec_unit

`default_nettype wire

//--- vec_unit.sv
// Vector unit top: dispatcher, lane array and result collector behind the core request port

`default_nettype none

module vec_unit #(
  parameter int unsigned NrLanes = 4
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,
  // Core request
  input  wire logic                         req_valid_i,
  output      logic                         req_ready_o,
  input  wire vec_pkg::vec_op_e             req_op_i,
  input  wire vec_pkg::vreg_idx_t           req_vd_i,
  input  wire vec_pkg::vreg_idx_t           req_vs1_i,
  input  wire vec_pkg::vreg_idx_t           req_vs2_i,
  input  wire vec_pkg::elem_t               req_scalar_i,
  input  wire vec_pkg::elem_t [NrLanes-1:0] req_vec_i,
  // Core response
  output      logic                         resp_valid_o,
  output      vec_pkg::elem_t               resp_data_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Dispatcher
  ////////////////////////////////////////////////////////////////////////////

  vec_issue_if #(.NrLanes(NrLanes)) i_issue_if ();

  // Broadcast chain, entry k feeds lane k; the last entry runs off the end
  logic           [NrLanes:0] bc_valid;
  vec_pkg::elem_t [NrLanes:0] bc_data;

  vec_dispatcher #(
    .NrLanes(NrLanes)
  ) i_dispatcher (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .req_op_i    (req_op_i    ),
    .req_vd_i    (req_vd_i    ),
    .req_vs1_i   (req_vs1_i   ),
    .req_vs2_i   (req_vs2_i   ),
    .req_scalar_i(req_scalar_i),
    .req_vec_i   (req_vec_i   ),
    .done_i      (resp_valid_o),
    .issue       (i_issue_if  ),
    .bc_valid_o  (bc_valid[0] ),
    .bc_data_o   (bc_data[0]  )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////////////////////

  logic           [NrLanes-1:0] lane_res_valid;
  vec_pkg::elem_t [NrLanes-1:0] lane_res_data;

  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lanes
    vec_lane #(
      .NrLanes(NrLanes),
      .LaneIdx(lane   )
    ) i_lane (
      .clk_i      (clk_i               ),
      .rst_n_i    (rst_n_i             ),
      .issue      (i_issue_if          ),
      .bc_valid_i (bc_valid[lane]      ),
      .bc_data_i  (bc_data[lane]       ),
      .bc_valid_o (bc_valid[lane+1]    ),
      .bc_data_o  (bc_data[lane+1]     ),
      .res_valid_o(lane_res_valid[lane]),
      .res_data_o (lane_res_data[lane] )
    );
  end : gen_lanes

  ////////////////////////////////////////////////////////////////////////////
  // Collector
  ////////////////////////////////////////////////////////////////////////////

  vec_result_collector #(
    .NrLanes(NrLanes)
  ) i_collector (
    .clk_i           (clk_i         ),
    .rst_n_i         (rst_n_i       ),
    .lane_res_valid_i(lane_res_valid),
    .lane_res_data_i (lane_res_data ),
    .resp_valid_o    (resp_valid_o  ),
    .resp_data_o     (resp_data_o   )
  );

endmodule : vec_unit

`default_nettype wire

//--- vec_result_collector.sv
// Result collector: sums the lane results of one instruction and pulses the response

`default_nettype none

module vec_result_collector #(
  parameter int unsigned NrLanes = 4
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,
  // Lane result strobes
  input  wire logic [NrLanes-1:0]           lane_res_valid_i,
  input  wire vec_pkg::elem_t [NrLanes-1:0] lane_res_data_i,
  // Response, also the completion to the dispatcher
  output      logic                         resp_valid_o,
  output      vec_pkg::elem_t               resp_data_o
);

  // Lanes already reported for the current instruction
  logic [NrLanes-1:0] seen_q, seen_d;
  vec_pkg::elem_t     sum_q, sum_d;
  logic               complete;

  // Works for simultaneous and staggered strobes alike
  always_comb begin
    sum_d = sum_q;
    for (int i = 0; i < NrLanes; i++) begin
      if (lane_res_valid_i[i]) begin
        sum_d = sum_d + lane_res_data_i[i];
      end
    end
  end

  assign seen_d   = seen_q | lane_res_valid_i;
  assign complete = &seen_d;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seen_q       <= '0;
      sum_q        <= '0;
      resp_valid_o <= 1'b0;
      resp_data_o  <= '0;
    end else begin
      resp_valid_o <= complete;
      if (complete) begin
        // Emit and start over
        resp_data_o <= sum_d;
        seen_q      <= '0;
        sum_q       <= '0;
      end else begin
        seen_q <= seen_d;
        sum_q  <= sum_d;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  a_no_double_report : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (lane_res_valid_i & seen_q) == '0
  ) else $error("lane reported twice for one instruction");

endmodule : vec_result_collector

`default_nettype wire

//--- vec_lane.sv
// One vector lane: register slice, element ALU, broadcast hop and result strobe

`default_nettype none

module vec_lane #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned LaneIdx = 0
) (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  // Issue bus
  vec_issue_if.lane           issue,
  // Broadcast chain, one registered hop per lane
  input  wire logic           bc_valid_i,
  input  wire vec_pkg::elem_t bc_data_i,
  output      logic           bc_valid_o,
  output      vec_pkg::elem_t bc_data_o,
  // Result toward the collector
  output      logic           res_valid_o,
  output      vec_pkg::elem_t res_data_o
);

  // Register slice, one element per vector register
  vec_pkg::elem_t [vec_pkg::NrVRegs-1:0] vrf_q;

  vec_pkg::elem_t vs1_elem;
  vec_pkg::elem_t vs2_elem;
  vec_pkg::elem_t alu_res;
  logic           alu_wr;

  assign vs1_elem = vrf_q[issue.vs1];
  assign vs2_elem = vrf_q[issue.vs2];

  ////////////////////////////////////////////////////////////////////////////
  // Element ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_res = vs1_elem;
    alu_wr  = 1'b1;
    case (issue.op)
      vec_pkg::VOP_LOAD: alu_res = issue.vec_data[LaneIdx];
      vec_pkg::VOP_ADD:  alu_res = vs1_elem + vs2_elem;
      vec_pkg::VOP_SUB:  alu_res = vs1_elem - vs2_elem;
      vec_pkg::VOP_AND:  alu_res = vs1_elem & vs2_elem;
      vec_pkg::VOP_XOR:  alu_res = vs1_elem ^ vs2_elem;
      // Reduce only reports vs1
      default:           alu_wr  = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register write and result
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vrf_q       <= '0;
      res_valid_o <= 1'b0;
      res_data_o  <= '0;
    end else begin
      res_valid_o <= issue.issue_valid | bc_valid_i;
      if (bc_valid_i) begin
        vrf_q[issue.vd] <= bc_data_i;
        res_data_o      <= bc_data_i;
      end else if (issue.issue_valid) begin
        if (alu_wr) begin
          vrf_q[issue.vd] <= alu_res;
        end
        res_data_o <= alu_res;
      end
    end
  end

  // Broadcast hop toward the next lane
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bc_valid_o <= 1'b0;
    end else begin
      bc_valid_o <= bc_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bc_valid_i) begin
      bc_data_o <= bc_data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  if (LaneIdx >= NrLanes) begin : gen_idx_check
    $error("Lane index out of range");
  end

  // Dispatcher sends an instruction down one path only
  a_issue_xor_bcast : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(issue.issue_valid && bc_valid_i)
  ) else $error("lane %0d: issue and broadcast together", LaneIdx);

endmodule : vec_lane

`default_nettype wire

//--- vec_dispatcher.sv
// Dispatcher: takes one core request at a time and issues it to the lanes or the broadcast chain

`default_nettype none

module vec_dispatcher #(
  parameter int unsigned NrLanes = 4
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,
  // Core request
  input  wire logic                         req_valid_i,
  output      logic                         req_ready_o,
  input  wire vec_pkg::vec_op_e             req_op_i,
  input  wire vec_pkg::vreg_idx_t           req_vd_i,
  input  wire vec_pkg::vreg_idx_t           req_vs1_i,
  input  wire vec_pkg::vreg_idx_t           req_vs2_i,
  input  wire vec_pkg::elem_t               req_scalar_i,
  input  wire vec_pkg::elem_t [NrLanes-1:0] req_vec_i,
  // Completion from the collector
  input  wire logic                         done_i,
  // Issue bus to the lanes
  vec_issue_if.dispatcher                   issue,
  // Head of the broadcast chain
  output      logic                         bc_valid_o,
  output      vec_pkg::elem_t               bc_data_o
);

  vec_pkg::disp_state_e state_q, state_d;
  logic                 accept;
  logic                 is_bcast;

  assign req_ready_o = (state_q == vec_pkg::DISP_IDLE);
  assign accept      = req_valid_i & req_ready_o;
  assign is_bcast    = (req_op_i == vec_pkg::VOP_BCAST);

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      vec_pkg::DISP_IDLE: if (accept) state_d = vec_pkg::DISP_BUSY;
      vec_pkg::DISP_BUSY: if (done_i) state_d = vec_pkg::DISP_IDLE;
      default:            state_d = vec_pkg::DISP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q           <= vec_pkg::DISP_IDLE;
      issue.issue_valid <= 1'b0;
      bc_valid_o        <= 1'b0;
    end else begin
      state_q <= state_d;
      // Strobes last exactly one cycle after acceptance
      issue.issue_valid <= accept & ~is_bcast;
      bc_valid_o        <= accept & is_bcast;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Instruction payload
  ////////////////////////////////////////////////////////////////////////////

  // Held for the whole instruction, the broadcast hops still need vd
  always_ff @(posedge clk_i) begin
    if (accept) begin
      issue.op       <= req_op_i;
      issue.vd       <= req_vd_i;
      issue.vs1      <= req_vs1_i;
      issue.vs2      <= req_vs2_i;
      issue.vec_data <= req_vec_i;
      bc_data_o      <= req_scalar_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Collector only completes what was accepted
  a_done_only_busy : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    done_i |-> (state_q == vec_pkg::DISP_BUSY)
  ) else $error("done seen while dispatcher idle");

endmodule : vec_dispatcher

`default_nettype wire

//--- vec_issue_if.sv
// Issue bus from the dispatcher to all lanes; one instance is shared by every lane

`default_nettype none

interface vec_issue_if #(
  parameter int unsigned NrLanes = 4
);

  // One-cycle issue strobe
  logic                               issue_valid;
  vec_pkg::vec_op_e                   op;
  vec_pkg::vreg_idx_t                 vd;
  vec_pkg::vreg_idx_t                 vs1;
  vec_pkg::vreg_idx_t                 vs2;
  // Whole load vector, lane 0 in the low bits
  vec_pkg::elem_t [NrLanes-1:0]       vec_data;

  modport dispatcher (
    output issue_valid, op, vd, vs1, vs2, vec_data
  );

  modport lane (
    input issue_valid, op, vd, vs1, vs2, vec_data
  );

endinterface : vec_issue_if

`default_nettype wire

//--- vec_pkg.sv
// Shared sizes, element types and enums for the vector unit; referenced by scoped names

`default_nettype none

package vec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 8;

  // One element in one lane
  typedef logic [ElemWidth-1:0] elem_t;

  // Register index into the per-lane slice
  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    VOP_LOAD   = 3'd0,
    VOP_ADD    = 3'd1,
    VOP_SUB    = 3'd2,
    VOP_AND    = 3'd3,
    VOP_XOR    = 3'd4,
    VOP_BCAST  = 3'd5,
    VOP_REDSUM = 3'd6
  } vec_op_e;

  typedef enum logic {
    DISP_IDLE = 1'b0,
    DISP_BUSY = 1'b1
  } disp_state_e;

endpackage : vec_pkg

`default_nettype wire
